/* common/tilt_game_pkg.sv */
`default_nettype none

package tilt_game_pkg;

    localparam int COORD_W = 10;
    localparam int FIELD_W = 320;
    localparam int FIELD_H = 180;
    localparam int SPRITE = 32;
    localparam int X_RANGE = FIELD_W - SPRITE;   // 288
    localparam int Y_RANGE = FIELD_H - SPRITE;   // 148
    localparam int FAIL_HOLES = 7;
    // x group then y group: fail holes, win hole, ball start
    localparam int LAYOUT_W = 2 * (FAIL_HOLES + 2) * COORD_W;
    localparam int NUM_LEVELS = 10;
    localparam int CAPTURE_R = 14;
    localparam int TILT_SHIFT = 4;

    typedef enum logic [3:0] {
        START_MENU = 4'h0,
        PLAYING    = 4'h1,
        FAIL       = 4'h2,
        WIN        = 4'h3,
        NEW        = 4'h4,
        AGAIN      = 4'h5,
        BALL_RST   = 4'h6,
        PAUSE      = 4'h7,
        NEW_RST    = 4'h8,
        FINISH     = 4'h9
    } game_state_e;

    typedef enum logic {
        CLASSIC = 1'b0,
        ENDLESS = 1'b1
    } game_mode_e;

    // msb first: start y, win y, fail y 6..0, start x, win x, fail x 6..0
    localparam logic [LAYOUT_W-1:0] LEVEL_TABLE [NUM_LEVELS] = '{
        {10'd20, 10'd60, 10'd130, 10'd140, 10'd100, 10'd130, 10'd120, 10'd80, 10'd10,
         10'd20, 10'd120, 10'd150, 10'd270, 10'd180, 10'd100, 10'd30, 10'd250, 10'd200},
        {10'd20, 10'd90, 10'd10, 10'd120, 10'd130, 10'd130, 10'd130, 10'd70, 10'd20,
         10'd250, 10'd150, 10'd90, 10'd270, 10'd200, 10'd100, 10'd30, 10'd60, 10'd20},
        {10'd120, 10'd40, 10'd10, 10'd60, 10'd10, 10'd140, 10'd140, 10'd100, 10'd20,
         10'd140, 10'd40, 10'd90, 10'd160, 10'd270, 10'd10, 10'd180, 10'd250, 10'd200},
        {10'd70, 10'd70, 10'd140, 10'd10, 10'd130, 10'd120, 10'd20, 10'd120, 10'd20,
         10'd10, 10'd270, 10'd210, 10'd150, 10'd30, 10'd240, 10'd180, 10'd120, 10'd60},
        {10'd10, 10'd130, 10'd130, 10'd100, 10'd30, 10'd20, 10'd110, 10'd80, 10'd40,
         10'd140, 10'd140, 10'd260, 10'd30, 10'd220, 10'd60, 10'd100, 10'd180, 10'd100},
        {10'd130, 10'd80, 10'd120, 10'd140, 10'd40, 10'd30, 10'd100, 10'd60, 10'd10,
         10'd270, 10'd190, 10'd30, 10'd80, 10'd240, 10'd160, 10'd120, 10'd60, 10'd10},
        {10'd130, 10'd90, 10'd90, 10'd110, 10'd20, 10'd60, 10'd120, 10'd50, 10'd40,
         10'd50, 10'd130, 10'd10, 10'd270, 10'd250, 10'd200, 10'd160, 10'd90, 10'd20},
        {10'd50, 10'd110, 10'd80, 10'd140, 10'd30, 10'd10, 10'd60, 10'd120, 10'd20,
         10'd200, 10'd260, 10'd40, 10'd180, 10'd280, 10'd230, 10'd100, 10'd150, 10'd150},
        {10'd100, 10'd30, 10'd60, 10'd120, 10'd40, 10'd90, 10'd140, 10'd130, 10'd20,
         10'd100, 10'd30, 10'd270, 10'd240, 10'd200, 10'd150, 10'd60, 10'd10, 10'd130},
        {10'd140, 10'd140, 10'd20, 10'd30, 10'd70, 10'd110, 10'd100, 10'd110, 10'd100,
         10'd20, 10'd270, 10'd40, 10'd130, 10'd250, 10'd210, 10'd160, 10'd110, 10'd60}
    };

endpackage

`default_nettype wire

/* source/button_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module button_pulse (
    input  logic CLK,
    input  logic rst,
    input  logic i_raw,
    output logic o_level,
    output logic o_pulse
);

    logic sync_1;
    logic sync_2;
    logic level_d;

    always_ff @(posedge CLK) begin
        if (rst) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            level_d <= 1'b0;
            o_pulse <= 1'b0;
        end else begin
            sync_1 <= i_raw;
            sync_2 <= sync_1;
            level_d <= sync_2;
            o_pulse <= sync_2 & ~level_d;   // rising edge only
        end
    end

    assign o_level = sync_2;

endmodule

`default_nettype wire

/* layout/hole_layout.sv */
`timescale 1ns/1ps
`default_nettype none

module hole_layout import tilt_game_pkg::*; #(
    parameter int X_LIMIT = X_RANGE,
    parameter int Y_LIMIT = Y_RANGE
) (
    input  logic                CLK,
    input  logic                rst,
    input  logic                i_restart,
    input  logic [15:0]         i_seed,
    input  game_mode_e          i_mode,
    input  logic [3:0]          i_level,
    output logic                o_rand_ready,
    output logic [LAYOUT_W-1:0] o_layout
);

    localparam int FIELDS = LAYOUT_W / COORD_W;

    logic [15:0]         lfsr;
    logic [4:0]          count;
    logic [COORD_W-1:0]  cand;
    logic                accept;
    logic [LAYOUT_W-1:0] rand_word;

    assign cand = lfsr[COORD_W-1:0];
    // first half of the fields are x, the rest y
    assign accept = !o_rand_ready &&
                    ((count < FIELDS / 2) ? (cand < X_LIMIT) : (cand < Y_LIMIT));

    always_ff @(posedge CLK) begin
        if (rst || i_restart) begin
            lfsr <= (i_seed == 16'h0000) ? 16'h0001 : i_seed;   // lfsr must not be zero
            count <= '0;
            o_rand_ready <= 1'b0;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
            if (accept) begin
                count <= count + 5'd1;
                o_rand_ready <= (count == 5'(FIELDS - 1));
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            rand_word[count*COORD_W +: COORD_W] <= cand;
        end
    end

    assign o_layout = (i_mode == ENDLESS) ? rand_word
                    : LEVEL_TABLE[(i_level < NUM_LEVELS) ? i_level : 4'd0];

endmodule

`default_nettype wire

/* source/ball_motion.sv */
`timescale 1ns/1ps
`default_nettype none

module ball_motion import tilt_game_pkg::*; #(
    parameter int X_LIMIT = X_RANGE,
    parameter int Y_LIMIT = Y_RANGE
) (
    input  logic               CLK,
    input  logic               rst,
    input  logic               i_frame_tick,
    input  logic               i_run,
    input  logic               i_load,
    input  logic [COORD_W-1:0] i_start_x,
    input  logic [COORD_W-1:0] i_start_y,
    input  logic signed [7:0]  i_tilt_x,
    input  logic signed [7:0]  i_tilt_y,
    output logic [COORD_W-1:0] o_ball_x,
    output logic [COORD_W-1:0] o_ball_y
);

    // one axis: add scaled tilt, clamp to 0 .. lim-1
    function automatic logic [COORD_W-1:0] step(input logic [COORD_W-1:0] pos,
                                                input logic signed [7:0] tilt,
                                                input int lim);
        logic signed [COORD_W+1:0] sum;
        sum = $signed({2'b00, pos}) + (tilt >>> TILT_SHIFT);
        if (sum < 0)
            return '0;
        if (sum >= lim)
            return COORD_W'(lim - 1);
        return sum[COORD_W-1:0];
    endfunction

    always_ff @(posedge CLK) begin
        if (rst) begin
            o_ball_x <= COORD_W'(X_LIMIT / 2);   // centre
            o_ball_y <= COORD_W'(Y_LIMIT / 2);
        end else if (i_load) begin
            o_ball_x <= i_start_x;
            o_ball_y <= i_start_y;
        end else if (i_frame_tick && i_run) begin
            o_ball_x <= step(o_ball_x, i_tilt_x, X_LIMIT);
            o_ball_y <= step(o_ball_y, i_tilt_y, Y_LIMIT);
        end
    end

endmodule

`default_nettype wire

/* source/hole_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module hole_capture import tilt_game_pkg::*; (
    input  logic                CLK,
    input  logic                rst,
    input  logic                i_clear,
    input  logic                i_enable,
    input  logic [COORD_W-1:0]  i_ball_x,
    input  logic [COORD_W-1:0]  i_ball_y,
    input  logic [LAYOUT_W-1:0] i_layout,
    output logic                o_win,
    output logic                o_fail,
    output logic [COORD_W-1:0]  o_fall_x,
    output logic [COORD_W-1:0]  o_fall_y
);

    function automatic logic near(input logic [COORD_W-1:0] a, input logic [COORD_W-1:0] b);
        return ((a > b) ? (a - b) : (b - a)) < CAPTURE_R;
    endfunction

    logic               hit;
    logic               hit_fail;
    logic [COORD_W-1:0] hit_x;
    logic [COORD_W-1:0] hit_y;
    logic               capture;

    always_comb begin
        logic [COORD_W-1:0] hole_x;
        logic [COORD_W-1:0] hole_y;
        hit = 1'b0;
        hit_fail = 1'b0;
        hit_x = '0;
        hit_y = '0;
        // win hole scanned first, so a fail hole and the lowest index win
        for (int i = FAIL_HOLES; i >= 0; i--) begin
            hole_x = i_layout[i*COORD_W +: COORD_W];
            hole_y = i_layout[(i + FAIL_HOLES + 2)*COORD_W +: COORD_W];
            if (near(i_ball_x, hole_x) && near(i_ball_y, hole_y)) begin
                hit = 1'b1;
                hit_fail = (i < FAIL_HOLES);
                hit_x = hole_x;
                hit_y = hole_y;
            end
        end
    end

    assign capture = i_enable && hit && !o_win && !o_fail;

    always_ff @(posedge CLK) begin
        if (rst || i_clear) begin
            o_win <= 1'b0;
            o_fail <= 1'b0;
        end else if (capture) begin
            o_win <= !hit_fail;
            o_fail <= hit_fail;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            o_fall_x <= hit_x;   // ball pinned at hole
            o_fall_y <= hit_y;
        end
    end

endmodule

`default_nettype wire

/* game/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module game_fsm import tilt_game_pkg::*; (
    input  logic                CLK,
    input  logic                rst,
    input  logic                i_new_game,
    input  logic                i_again,
    input  logic                i_up,
    input  logic                i_down,
    input  logic                i_ok,
    input  logic                i_tilt_valid,
    input  logic                i_rand_ready,
    input  logic                i_win,
    input  logic                i_fail,
    input  logic [LAYOUT_W-1:0] i_layout,
    input  logic [COORD_W-1:0]  i_ball_x,
    input  logic [COORD_W-1:0]  i_ball_y,
    input  logic [COORD_W-1:0]  i_fall_x,
    input  logic [COORD_W-1:0]  i_fall_y,
    output logic                o_layout_restart,
    output logic                o_ball_load,
    output logic [COORD_W-1:0]  o_start_x,
    output logic [COORD_W-1:0]  o_start_y,
    output logic                o_ball_run,
    output logic                o_capture_clear,
    output logic                o_capture_enable,
    output game_mode_e          o_layout_sel_mode,
    output logic [3:0]          o_level,
    output game_state_e         o_game_state,
    output logic [2:0]          o_select_pos,
    output logic [COORD_W-1:0]  o_ball_x,
    output logic [COORD_W-1:0]  o_ball_y
);

    game_state_e state;
    game_mode_e  mode;
    logic [2:0]  max_option;

    // options on each screen
    always_comb begin
        case (state)
            START_MENU, WIN: max_option = 3'd2;
            PAUSE:           max_option = (mode == ENDLESS) ? 3'd3 : 3'd2;
            FAIL:            max_option = (mode == ENDLESS) ? 3'd2 : 3'd1;
            FINISH:          max_option = 3'd1;
            default:         max_option = 3'd3;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst || i_ok) begin
            o_select_pos <= '0;
        end else if (i_up && (o_select_pos > 3'd0)) begin
            o_select_pos <= o_select_pos - 3'd1;
        end else if (i_down && (o_select_pos < max_option - 3'd1)) begin
            o_select_pos <= o_select_pos + 3'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= START_MENU;
            mode <= CLASSIC;
            o_level <= '0;
            o_start_x <= COORD_W'(X_RANGE / 2);
            o_start_y <= COORD_W'(Y_RANGE / 2);
        end else if (i_new_game) begin
            state <= NEW_RST;
        end else begin
            case (state)
                START_MENU: if (i_ok) begin
                    if (o_select_pos == 3'd0) begin
                        mode <= CLASSIC;
                        o_level <= '0;
                        state <= NEW;
                    end else begin
                        mode <= ENDLESS;
                        state <= NEW_RST;
                    end
                end
                NEW_RST: state <= NEW;
                NEW: if (i_tilt_valid && ((mode == CLASSIC) || i_rand_ready)) begin
                    o_start_x <= i_layout[(FAIL_HOLES + 1)*COORD_W +: COORD_W];
                    o_start_y <= i_layout[(2*FAIL_HOLES + 3)*COORD_W +: COORD_W];
                    state <= BALL_RST;
                end
                BALL_RST, AGAIN: state <= PLAYING;
                PLAYING: begin
                    if (i_fail)
                        state <= FAIL;
                    else if (i_win)
                        state <= WIN;
                    else if (i_ok)
                        state <= PAUSE;
                end
                PAUSE: if (i_ok) begin
                    if (o_select_pos == 3'd0)
                        state <= PLAYING;
                    else if (o_select_pos == 3'd1)
                        state <= AGAIN;
                    else if (mode == ENDLESS)
                        state <= NEW_RST;
                end
                FAIL: if (i_ok) begin
                    if (o_select_pos == 3'd0)
                        state <= AGAIN;
                    else if (mode == ENDLESS)
                        state <= NEW_RST;
                end
                WIN: if (i_ok) begin
                    if (o_select_pos == 3'd0) begin
                        state <= AGAIN;
                    end else if (mode == ENDLESS) begin
                        state <= NEW_RST;
                    end else if (o_level < 4'(NUM_LEVELS - 1)) begin
                        o_level <= o_level + 4'd1;   // next classic level
                        state <= NEW_RST;
                    end else begin
                        state <= FINISH;
                    end
                end
                FINISH: if (i_ok) state <= START_MENU;
                default: state <= START_MENU;
            endcase
        end
    end

    always_comb begin
        case (state)
            START_MENU, PLAYING, PAUSE: begin
                o_ball_x = i_ball_x;
                o_ball_y = i_ball_y;
            end
            FAIL, WIN: begin
                o_ball_x = i_fall_x;
                o_ball_y = i_fall_y;
            end
            default: begin
                o_ball_x = o_start_x;
                o_ball_y = o_start_y;
            end
        endcase
    end

    assign o_layout_restart = (state == NEW_RST);
    assign o_ball_load = (state == BALL_RST) || (state == AGAIN);
    assign o_ball_run = (state == PLAYING) || (state == START_MENU);
    assign o_capture_enable = (state == PLAYING);
    assign o_capture_clear = i_again || i_new_game || (state == NEW_RST) ||
                             (state == BALL_RST) || (state == AGAIN);
    assign o_layout_sel_mode = mode;
    assign o_game_state = state;

endmodule

`default_nettype wire

/* source/tilt_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tilt_game_top import tilt_game_pkg::*; #(
    parameter int X_LIMIT = X_RANGE,
    parameter int Y_LIMIT = Y_RANGE
) (
    input  logic               CLK,
    input  logic               rst,
    input  logic               i_new_game_btn,
    input  logic               i_again_btn,
    input  logic               i_up_btn,
    input  logic               i_down_btn,
    input  logic               i_ok_btn,
    input  logic               i_frame_tick,
    input  logic signed [7:0]  i_tilt_x,
    input  logic signed [7:0]  i_tilt_y,
    input  logic               i_tilt_valid,
    output game_state_e        o_game_state,
    output game_mode_e         o_game_mode,
    output logic [3:0]         o_level,
    output logic [2:0]         o_select_pos,
    output logic [COORD_W-1:0] o_ball_x,
    output logic [COORD_W-1:0] o_ball_y
);

    logic new_level, new_pulse, ok_level, ok_pulse;
    logic again_pulse, up_pulse, down_pulse;
    logic [15:0] seed_cnt;
    logic rand_ready, layout_restart;
    logic [LAYOUT_W-1:0] layout;
    logic ball_load, ball_run;
    logic [COORD_W-1:0] start_x, start_y, roll_x, roll_y, fall_x, fall_y;
    logic capture_clear, capture_enable, win, fail;

    button_pulse u_btn_new (.CLK(CLK), .rst(rst), .i_raw(i_new_game_btn),
                            .o_level(new_level), .o_pulse(new_pulse));
    button_pulse u_btn_again (.CLK(CLK), .rst(rst), .i_raw(i_again_btn),
                              .o_level(), .o_pulse(again_pulse));
    button_pulse u_btn_up (.CLK(CLK), .rst(rst), .i_raw(i_up_btn),
                           .o_level(), .o_pulse(up_pulse));
    button_pulse u_btn_down (.CLK(CLK), .rst(rst), .i_raw(i_down_btn),
                             .o_level(), .o_pulse(down_pulse));
    button_pulse u_btn_ok (.CLK(CLK), .rst(rst), .i_raw(i_ok_btn),
                           .o_level(ok_level), .o_pulse(ok_pulse));

    // press activity as the random seed
    always_ff @(posedge CLK) begin
        if (rst)
            seed_cnt <= '0;
        else if (ok_level || new_level)
            seed_cnt <= seed_cnt + 16'd1;
    end

    hole_layout #(.X_LIMIT(X_LIMIT), .Y_LIMIT(Y_LIMIT)) u_layout (
        .CLK(CLK), .rst(rst), .i_restart(layout_restart), .i_seed(seed_cnt),
        .i_mode(o_game_mode), .i_level(o_level),
        .o_rand_ready(rand_ready), .o_layout(layout)
    );

    ball_motion #(.X_LIMIT(X_LIMIT), .Y_LIMIT(Y_LIMIT)) u_motion (
        .CLK(CLK), .rst(rst), .i_frame_tick(i_frame_tick), .i_run(ball_run),
        .i_load(ball_load), .i_start_x(start_x), .i_start_y(start_y),
        .i_tilt_x(i_tilt_x), .i_tilt_y(i_tilt_y), .o_ball_x(roll_x), .o_ball_y(roll_y)
    );

    hole_capture u_capture (
        .CLK(CLK), .rst(rst), .i_clear(capture_clear), .i_enable(capture_enable),
        .i_ball_x(roll_x), .i_ball_y(roll_y), .i_layout(layout),
        .o_win(win), .o_fail(fail), .o_fall_x(fall_x), .o_fall_y(fall_y)
    );

    game_fsm u_fsm (
        .CLK(CLK), .rst(rst), .i_new_game(new_pulse), .i_again(again_pulse),
        .i_up(up_pulse), .i_down(down_pulse), .i_ok(ok_pulse),
        .i_tilt_valid(i_tilt_valid), .i_rand_ready(rand_ready), .i_win(win), .i_fail(fail),
        .i_layout(layout), .i_ball_x(roll_x), .i_ball_y(roll_y),
        .i_fall_x(fall_x), .i_fall_y(fall_y),
        .o_layout_restart(layout_restart), .o_ball_load(ball_load),
        .o_start_x(start_x), .o_start_y(start_y), .o_ball_run(ball_run),
        .o_capture_clear(capture_clear), .o_capture_enable(capture_enable),
        .o_layout_sel_mode(o_game_mode), .o_level(o_level), .o_game_state(o_game_state),
        .o_select_pos(o_select_pos), .o_ball_x(o_ball_x), .o_ball_y(o_ball_y)
    );

endmodule

`default_nettype wire

/* verif/tilt_game_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tilt_game_checker import tilt_game_pkg::*; (
    input logic               CLK,
    input logic               rst,
    input game_state_e        i_state,
    input game_mode_e         i_mode,
    input logic [COORD_W-1:0] i_ball_x,
    input logic [COORD_W-1:0] i_ball_y
);

    int   failures = 0;   // failed assertion count
    logic ball_legal;

    assign ball_legal = (i_ball_x < X_RANGE) && (i_ball_y < Y_RANGE);

    // random start lands inside the field, then play begins
    a_endless_start: assert property (@(posedge CLK) disable iff (rst)
        (i_state == BALL_RST && i_mode == ENDLESS) |->
            ball_legal ##1 (i_state == PLAYING && ball_legal))
    else begin
        failures++;
        $error("endless start position outside the playfield");
    end

    a_ball_range: assert property (@(posedge CLK) disable iff (rst) ball_legal)
    else begin
        failures++;
        $error("ball position outside the playfield");
    end

    a_state_legal: assert property (@(posedge CLK) disable iff (rst)
        i_state inside {START_MENU, NEW_RST, NEW, BALL_RST, AGAIN,
                        PLAYING, PAUSE, FAIL, WIN, FINISH})
    else begin
        failures++;
        $error("game state outside the state set");
    end

endmodule

bind tilt_game_top tilt_game_checker u_checker (
    .CLK(CLK), .rst(rst), .i_state(o_game_state), .i_mode(o_game_mode),
    .i_ball_x(o_ball_x), .i_ball_y(o_ball_y)
);

`default_nettype wire

/* verif/tilt_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tilt_game_tb import tilt_game_pkg::*; ();

    localparam real PERIOD = 4.0;
    localparam int PRESS_CYC = 8;
    localparam int FRAME_CYC = 4;
    localparam int WAIT_LIMIT = 2000;
    localparam int MAX_STEER = 60;
    // two resets, presses, frames and state waits of the whole run
    localparam int TEST_CYC = 10 + 11 * PRESS_CYC + (15 + 2 * MAX_STEER) * FRAME_CYC
                            + 6 * WAIT_LIMIT;
    localparam real LIMIT_NS = TEST_CYC * PERIOD + 1000.0;
    localparam int B_NEW = 0;
    localparam int B_AGAIN = 1;
    localparam int B_UP = 2;
    localparam int B_DOWN = 3;
    localparam int B_OK = 4;

    logic               CLK;
    logic               rst;
    logic [4:0]         btn;
    logic               frame_tick;
    logic signed [7:0]  tilt_x;
    logic signed [7:0]  tilt_y;
    logic               tilt_valid;
    game_state_e        game_state;
    game_mode_e         game_mode;
    logic [3:0]         level;
    logic [2:0]         select_pos;
    logic [COORD_W-1:0] ball_x;
    logic [COORD_W-1:0] ball_y;

    logic [31:0]         lfsr = 32'hdc36781e;
    logic [LAYOUT_W-1:0] lay;
    int mx;
    int my;
    int level_m;
    int cur;
    int value_errors = 0;
    int other_errors = 0;

    tilt_game_top u_dut (
        .CLK(CLK), .rst(rst),
        .i_new_game_btn(btn[B_NEW]), .i_again_btn(btn[B_AGAIN]), .i_up_btn(btn[B_UP]),
        .i_down_btn(btn[B_DOWN]), .i_ok_btn(btn[B_OK]),
        .i_frame_tick(frame_tick), .i_tilt_x(tilt_x), .i_tilt_y(tilt_y),
        .i_tilt_valid(tilt_valid),
        .o_game_state(game_state), .o_game_mode(game_mode), .o_level(level),
        .o_select_pos(select_pos), .o_ball_x(ball_x), .o_ball_y(ball_y)
    );

    always #(PERIOD / 2) CLK = ~CLK;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // field i of a layout word, x fields first
    function automatic int field(input logic [LAYOUT_W-1:0] w, input int i);
        return int'(w[i*COORD_W +: COORD_W]);
    endfunction

    // floor of tilt / 16, then kept inside 0 .. lim-1
    function automatic int model_move(input int pos, input int tilt, input int lim);
        int d;
        int div;
        div = 1 << TILT_SHIFT;
        d = (tilt >= 0) ? tilt / div : -((div - 1 - tilt) / div);
        if (pos + d < 0)
            return 0;
        if (pos + d > lim - 1)
            return lim - 1;
        return pos + d;
    endfunction

    // fail holes by index first, win hole last
    function automatic int find_hole(input int x, input int y);
        int dx;
        int dy;
        for (int i = 0; i <= FAIL_HOLES; i++) begin
            dx = x - field(lay, i);
            dy = y - field(lay, i + FAIL_HOLES + 2);
            if (dx < CAPTURE_R && dx > -CAPTURE_R && dy < CAPTURE_R && dy > -CAPTURE_R)
                return i;
        end
        return -1;
    endfunction

    function automatic int limit_step(input int d);
        return (d > 7) ? 7 : ((d < -8) ? -8 : d);
    endfunction

    task automatic check_val(input string name, input int exp, input int got);
        assert (exp == got) else begin
            value_errors++;
            $display("** Error [%s] expected %0d, actual %0d", name, exp, got);
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #0.5;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) next_cycle();
        rst = 1'b0;
    endtask

    task automatic press(input int b);
        btn[b] = 1'b1;
        repeat (2) next_cycle();
        btn[b] = 1'b0;
        repeat (PRESS_CYC - 2) next_cycle();
    endtask

    task automatic wait_state(input game_state_e target, input string name);
        int n;
        n = 0;
        while (game_state != target && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        assert (game_state == target) else begin
            other_errors++;
            $display("%s: state %0d not reached within %0d cycles", name, target, WAIT_LIMIT);
        end
    endtask

    task automatic run_frame(input logic signed [7:0] tx, input logic signed [7:0] ty,
                             input string name, output int hit);
        tilt_x = tx;
        tilt_y = ty;
        frame_tick = 1'b1;
        next_cycle();
        frame_tick = 1'b0;
        mx = model_move(mx, tx, X_RANGE);
        my = model_move(my, ty, Y_RANGE);
        check_val({name, " ball x"}, mx, ball_x);
        check_val({name, " ball y"}, my, ball_y);
        hit = find_hole(mx, my);
        if (hit < 0) begin
            repeat (FRAME_CYC - 1) next_cycle();
            check_val({name, " state"}, PLAYING, game_state);
        end
    endtask

    // roll toward hole idx until the model sees a capture
    task automatic steer_to(input int idx, input string name);
        int hit;
        int n;
        int sx;
        int sy;
        logic [7:0] rx;
        logic [7:0] ry;
        hit = -1;
        n = 0;
        while (hit < 0 && n < MAX_STEER) begin
            sx = limit_step(field(lay, idx) - mx);
            sy = limit_step(field(lay, idx + FAIL_HOLES + 2) - my);
            rand_bits(4, rx);
            rand_bits(4, ry);
            run_frame(8'(sx * 16 + int'(rx)), 8'(sy * 16 + int'(ry)), name, hit);
            n++;
        end
        assert (hit >= 0) else begin
            other_errors++;
            $display("%s: ball did not reach the target hole in %0d frames", name, MAX_STEER);
        end
        if (hit >= 0) begin
            check_val({name, " hole"}, idx, hit);
            wait_state((hit == FAIL_HOLES) ? WIN : FAIL, name);
            check_val({name, " fall x"}, field(lay, hit), ball_x);
            check_val({name, " fall y"}, field(lay, hit + FAIL_HOLES + 2), ball_y);
        end
    endtask

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [7:0] rx;
        logic [7:0] ry;
        int hit;
        CLK = 1'b0;
        rst = 1'b1;
        btn = '0;
        frame_tick = 1'b0;
        tilt_x = '0;
        tilt_y = '0;
        tilt_valid = 1'b0;
        apply_reset();

        check_val("reset state", START_MENU, game_state);
        check_val("reset cursor", 0, select_pos);
        check_val("reset level", 0, level);
        check_val("reset mode", CLASSIC, game_mode);

        cur = 0;   // two options on the start screen
        repeat (3) begin
            press(B_DOWN);
            cur = (cur < 1) ? cur + 1 : cur;
            check_val("menu down", cur, select_pos);
        end
        repeat (3) begin
            press(B_UP);
            cur = (cur > 0) ? cur - 1 : cur;
            check_val("menu up", cur, select_pos);
        end

        level_m = 0;
        lay = LEVEL_TABLE[level_m];
        press(B_OK);
        check_val("classic wait tilt", NEW, game_state);
        tilt_valid = 1'b1;
        wait_state(BALL_RST, "classic start");
        mx = field(lay, FAIL_HOLES + 1);
        my = field(lay, 2 * FAIL_HOLES + 3);
        check_val("ball_rst x", mx, ball_x);
        check_val("ball_rst y", my, ball_y);
        next_cycle();
        check_val("classic playing", PLAYING, game_state);
        check_val("start x", mx, ball_x);
        check_val("start y", my, ball_y);

        repeat (3) run_frame(8'h80, 8'h80, "clamp low", hit);   // into the corner
        repeat (6) begin
            rand_bits(8, rx);
            rand_bits(8, ry);
            run_frame(rx, ry, "random tilt", hit);
        end
        steer_to(FAIL_HOLES, "win level 0");

        press(B_DOWN);
        check_val("win cursor", 1, select_pos);
        press(B_OK);
        level_m = level_m + 1;
        lay = LEVEL_TABLE[level_m];
        wait_state(PLAYING, "next level");
        check_val("next level", level_m, level);
        mx = field(lay, FAIL_HOLES + 1);
        my = field(lay, 2 * FAIL_HOLES + 3);
        check_val("level 1 start x", mx, ball_x);
        check_val("level 1 start y", my, ball_y);

        repeat (6) begin
            rand_bits(4, rx);
            run_frame(8'(112 + int'(rx)), 8'(rx), "clamp high", hit);
        end
        steer_to(6, "fail level 1");

        // endless game from a fresh start menu
        apply_reset();
        press(B_DOWN);
        press(B_OK);
        check_val("endless mode", ENDLESS, game_mode);
        wait_state(PLAYING, "endless start");
        repeat (4) next_cycle();

        $display("value errors: %0d, other failures: %0d, assertion failures: %0d",
                 value_errors, other_errors, u_dut.u_checker.failures);
        if (value_errors + other_errors + u_dut.u_checker.failures == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/tilt_game_pkg.sv
source/button_pulse.sv
layout/hole_layout.sv
source/ball_motion.sv
source/hole_capture.sv
game/game_fsm.sv
source/tilt_game_top.sv
verif/tilt_game_checker.sv
verif/tilt_game_tb.sv
